//--- dcache.f
src/dcache_pkg.sv
src/dcache_request_hold.sv
src/dcache_mem.sv
src/dcache_writeback_port.sv
src/dcache.sv
verification/dcache_mem_model.sv
verification/dcache_tb.sv

//--- run_sim.sh
#!/bin/sh
# builds the dcache testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary -j 0 --top-module dcache_tb -f dcache.f -o sim_dcache
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

output=$(./obj_dir/sim_dcache)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$output" | grep -qx "Test completed successfully"; then
	exit 0
fi
exit 1

//--- verification/dcache_tb.sv
`timescale 1ns/100ps

module dcache_tb;

	typedef logic [dcache_pkg::addr_bits-1:0] block_addr_t;
	typedef logic [dcache_pkg::block_bits-1:0] block_t;
	typedef struct packed
	{
		logic write;
		block_addr_t addr;
		block_t data;
	} request_t;

	localparam int half_period = 4;
	localparam int access_total = 220;
	localparam int watchdog_cycles = 40 * access_total + 10;
	localparam logic [15:0] lfsr_seed = 16'd41344;

	logic clock;
	logic reset;
	logic proc_read;
	logic proc_write;
	block_addr_t proc_addr;
	block_t proc_write_data;
	logic proc_busy;
	logic proc_done;
	block_t proc_read_data;
	dcache_pkg::bus_command_t mem_command;
	block_addr_t mem_addr;
	block_t mem_store_data;
	logic [dcache_pkg::response_bits-1:0] mem_response;
	logic [dcache_pkg::response_bits-1:0] mem_tag;
	block_t mem_load_data;

	// requests not yet done in issue order
	request_t outstanding [$];
	block_t written [block_addr_t];
	logic [15:0] lfsr_state = lfsr_seed;
	string test_name = "reset";
	int check_count = 0;
	int error_count = 0;
	int test_errors = 0;
	int load_count = 0;

	dcache dut (.*);
	dcache_mem_model memory (.*);

	initial
	begin
		clock = 1'b0;
		forever
			#(half_period) clock = ~clock;
	end

	// budget of 40 cycles per access
	initial
	begin
		repeat (watchdog_cycles) @(posedge clock);
		$display("timeout: the accesses did not finish within %0d cycles", watchdog_cycles);
		$display("Test failed");
		$finish;
	end

	function automatic block_t initial_block(block_addr_t addr);
		return {addr ^ 16'hc3a5, ~addr, {addr[7:0], addr[15:8]}, addr + 16'h2b6d};
	endfunction

	// last block written or the memory's initial block
	function automatic block_t expected_block(block_addr_t addr);
		if (written.exists(addr))
			return written[addr];
		return initial_block(addr);
	endfunction

	function automatic logic [15:0] lfsr_next(logic [15:0] state);
		return state[0] ? (state >> 1) ^ 16'hb400 : state >> 1;
	endfunction

	task automatic take_bits(input int count, output block_t value);
		value = '0;
		for (int i = 0; i < count; i++)
		begin
			value = {value[dcache_pkg::block_bits-2:0], lfsr_state[0]};
			lfsr_state = lfsr_next(lfsr_state);
		end
	endtask

	task automatic check_value(input string what, input block_t expected, input block_t actual);
		check_count++;
		if (expected !== actual)
		begin
			error_count++;
			test_errors++;
			$display("MISMATCH %s: %s expected %h actual %h", test_name, what, expected, actual);
		end
	endtask

	always @(negedge clock)
	begin
		request_t finished;
		if (!reset && proc_done)
		begin
			finished = outstanding.pop_front();
			if (finished.write)
				written[finished.addr] = finished.data;
			else
				check_value($sformatf("read %h", finished.addr),
					expected_block(finished.addr), proc_read_data);
		end
	end

	always @(negedge clock)
	begin
		if (!reset && mem_command == dcache_pkg::bus_load)
			load_count++;
	end

	task automatic drive_request(input logic write, input block_addr_t addr, input block_t data);
		outstanding.push_back({write, addr, data});
		proc_read = !write;
		proc_write = write;
		proc_addr = addr;
		proc_write_data = data;
	endtask

	// strobe is taken at the rising edge after an idle falling edge
	task automatic wait_accept();
		while (proc_busy)
			@(negedge clock);
		@(negedge clock);
		proc_read = 1'b0;
		proc_write = 1'b0;
	endtask

	task automatic wait_done();
		while (!proc_done)
			@(negedge clock);
		@(negedge clock);
	endtask

	task automatic access(input logic write, input block_addr_t addr, input block_t data);
		drive_request(write, addr, data);
		wait_accept();
		wait_done();
	endtask

	task automatic begin_test(input string name);
		test_name = name;
		test_errors = 0;
	endtask

	task automatic end_test();
		$display("%s finished with %0d errors", test_name, test_errors);
	endtask

	initial
	begin
		block_t bits;
		int loads_before;
		logic is_write;
		int slot;

		reset = 1'b1;
		proc_read = 1'b0;
		proc_write = 1'b0;
		proc_addr = '0;
		proc_write_data = '0;
		repeat (3) @(negedge clock);
		reset = 1'b0;

		begin_test("cold_read");
		loads_before = load_count;
		access(1'b0, 16'h0123, '0);
		check_value("loads on first read", 64'd1, block_t'(load_count - loads_before));
		loads_before = load_count;
		access(1'b0, 16'h0123, '0);
		check_value("loads on repeat read", 64'd0, block_t'(load_count - loads_before));
		end_test();

		begin_test("write_then_read");
		access(1'b1, 16'h0241, 64'h0123_4567_89ab_cdef);
		access(1'b0, 16'h0241, '0);
		end_test();

		// three tags in the two ways of set 6
		begin_test("set_conflict");
		access(1'b1, 16'h0306, 64'h3333_0306_aaaa_0001);
		access(1'b1, 16'h030e, 64'h3333_030e_bbbb_0002);
		access(1'b1, 16'h0316, 64'h3333_0316_cccc_0003);
		access(1'b0, 16'h0306, '0);
		access(1'b0, 16'h030e, '0);
		access(1'b0, 16'h0316, '0);
		end_test();

		begin_test("lru_order");
		access(1'b0, 16'h0405, '0);
		access(1'b0, 16'h040d, '0);
		access(1'b0, 16'h0405, '0);
		access(1'b0, 16'h0415, '0);
		loads_before = load_count;
		access(1'b0, 16'h0405, '0);
		check_value("loads for recent line", 64'd0, block_t'(load_count - loads_before));
		loads_before = load_count;
		access(1'b0, 16'h040d, '0);
		check_value("loads for evicted line", 64'd1, block_t'(load_count - loads_before));
		end_test();

		begin_test("stall_on_fill");
		drive_request(1'b0, 16'h0502, '0);
		wait_accept();
		drive_request(1'b1, 16'h0607, 64'hfeed_beef_0607_0001);
		// busy holds for the whole fill
		while (!proc_done)
		begin
			check_value("busy during fill", 64'd1, block_t'(proc_busy));
			@(negedge clock);
		end
		@(negedge clock);
		wait_accept();
		drive_request(1'b0, 16'h0607, '0);
		wait_done();
		wait_accept();
		wait_done();
		access(1'b0, 16'h0502, '0);
		end_test();

		// six tags in each of sets 0 to 3
		begin_test("random_mix");
		for (int n = 0; n < 200; n++)
		begin
			take_bits(1, bits);
			is_write = bits[0];
			take_bits(5, bits);
			slot = int'(bits[4:0]) % 24;
			bits = '0;
			if (is_write)
				take_bits(64, bits);
			access(is_write, block_addr_t'((512 + slot / 4) * dcache_pkg::set_count + slot % 4),
				bits);
		end
		end_test();

		$display("%0d checks, %0d errors", check_count, error_count);
		if (error_count == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

//--- verification/dcache_mem_model.sv
`timescale 1ns/100ps

module dcache_mem_model (
	input logic clock,
	input logic reset,
	input dcache_pkg::bus_command_t mem_command,
	input logic [dcache_pkg::addr_bits-1:0] mem_addr,
	input logic [dcache_pkg::block_bits-1:0] mem_store_data,
	output logic [dcache_pkg::response_bits-1:0] mem_response,
	output logic [dcache_pkg::response_bits-1:0] mem_tag,
	output logic [dcache_pkg::block_bits-1:0] mem_load_data
);

	typedef logic [dcache_pkg::addr_bits-1:0] block_addr_t;
	typedef logic [dcache_pkg::block_bits-1:0] block_t;
	typedef logic [dcache_pkg::response_bits-1:0] response_t;

	localparam int load_latency = 6;
	localparam int tag_count = 1 << dcache_pkg::response_bits;
	localparam response_t first_tag = 1;

	// stored blocks only, everything else reads as the fill pattern
	block_t storage [block_addr_t];

	response_t next_tag;
	logic load_waiting [tag_count];
	block_addr_t load_addr [tag_count];
	int load_countdown [tag_count];

	function automatic block_t pattern_block(block_addr_t addr);
		return {addr ^ 16'hc3a5, ~addr, {addr[7:0], addr[15:8]}, addr + 16'h2b6d};
	endfunction

	function automatic block_t read_block(block_addr_t addr);
		if (storage.exists(addr))
			return storage[addr];
		return pattern_block(addr);
	endfunction

	// tag answers the load in the same cycle
	assign mem_response = (mem_command == dcache_pkg::bus_load) ? next_tag : '0;

	always @(posedge clock)
	begin
		if (reset)
		begin
			next_tag <= first_tag;
			mem_tag <= '0;
			mem_load_data <= '0;
			for (int t = 0; t < tag_count; t++)
				load_waiting[t] <= 1'b0;
		end
		else
		begin
			mem_tag <= '0;
			if (mem_command == dcache_pkg::bus_store)
				storage[mem_addr] = mem_store_data;
			for (int t = 1; t < tag_count; t++)
			begin
				if (load_waiting[t] && load_countdown[t] == 1)
				begin
					// data as it is at return time
					mem_tag <= response_t'(t);
					mem_load_data <= read_block(load_addr[t]);
					load_waiting[t] <= 1'b0;
				end
				else if (load_waiting[t])
					load_countdown[t] <= load_countdown[t] - 1;
			end
			if (mem_command == dcache_pkg::bus_load)
			begin
				load_waiting[next_tag] <= 1'b1;
				load_addr[next_tag] <= mem_addr;
				load_countdown[next_tag] <= load_latency;
				next_tag <= (next_tag == '1) ? first_tag : next_tag + first_tag;
			end
		end
	end

endmodule

//--- src/dcache.sv
`timescale 1ns/100ps

module dcache (
	input logic clock,
	input logic reset,

	// processor side
	input logic proc_read,
	input logic proc_write,
	input logic [dcache_pkg::addr_bits-1:0] proc_addr,
	input logic [dcache_pkg::block_bits-1:0] proc_write_data,
	output logic proc_busy,
	output logic proc_done,
	output logic [dcache_pkg::block_bits-1:0] proc_read_data,

	// memory bus
	output dcache_pkg::bus_command_t mem_command,
	output logic [dcache_pkg::addr_bits-1:0] mem_addr,
	output logic [dcache_pkg::block_bits-1:0] mem_store_data,
	input logic [dcache_pkg::response_bits-1:0] mem_response,
	input logic [dcache_pkg::response_bits-1:0] mem_tag,
	input logic [dcache_pkg::block_bits-1:0] mem_load_data
);

	logic lookup_read;
	logic lookup_write;
	logic [dcache_pkg::index_bits-1:0] lookup_index;
	logic [dcache_pkg::tag_bits-1:0] lookup_tag;
	logic [dcache_pkg::block_bits-1:0] lookup_write_data;
	logic fill_request;
	logic victim_write;
	logic [dcache_pkg::addr_bits-1:0] victim_addr;
	logic [dcache_pkg::block_bits-1:0] victim_data;
	logic writeback_busy;

	// access_done doubles as proc_done
	dcache_request_hold request_hold (
		.clock(clock),
		.reset(reset),
		.proc_read(proc_read),
		.proc_write(proc_write),
		.proc_addr(proc_addr),
		.proc_write_data(proc_write_data),
		.access_done(proc_done),
		.proc_busy(proc_busy),
		.lookup_read(lookup_read),
		.lookup_write(lookup_write),
		.lookup_index(lookup_index),
		.lookup_tag(lookup_tag),
		.lookup_write_data(lookup_write_data)
	);

	dcache_mem mem (
		.clock(clock),
		.reset(reset),
		.lookup_read(lookup_read),
		.lookup_write(lookup_write),
		.lookup_index(lookup_index),
		.lookup_tag(lookup_tag),
		.lookup_write_data(lookup_write_data),
		.writeback_busy(writeback_busy),
		.mem_response(mem_response),
		.mem_tag(mem_tag),
		.mem_load_data(mem_load_data),
		.access_done(proc_done),
		.read_data(proc_read_data),
		.fill_request(fill_request),
		.victim_write(victim_write),
		.victim_addr(victim_addr),
		.victim_data(victim_data)
	);

	dcache_writeback_port writeback_port (
		.clock(clock),
		.reset(reset),
		.fill_request(fill_request),
		.lookup_index(lookup_index),
		.lookup_tag(lookup_tag),
		.victim_write(victim_write),
		.victim_addr(victim_addr),
		.victim_data(victim_data),
		.writeback_busy(writeback_busy),
		.mem_command(mem_command),
		.mem_addr(mem_addr),
		.mem_store_data(mem_store_data)
	);

endmodule

//--- src/dcache_writeback_port.sv
`timescale 1ns/100ps

module dcache_writeback_port (
	input logic clock,
	input logic reset,
	input logic fill_request,
	input logic [dcache_pkg::index_bits-1:0] lookup_index,
	input logic [dcache_pkg::tag_bits-1:0] lookup_tag,
	input logic victim_write,
	input logic [dcache_pkg::addr_bits-1:0] victim_addr,
	input logic [dcache_pkg::block_bits-1:0] victim_data,
	output logic writeback_busy,
	output dcache_pkg::bus_command_t mem_command,
	output logic [dcache_pkg::addr_bits-1:0] mem_addr,
	output logic [dcache_pkg::block_bits-1:0] mem_store_data
);

	// one-entry writeback register
	logic held;
	logic [dcache_pkg::addr_bits-1:0] held_addr;
	logic [dcache_pkg::block_bits-1:0] held_data;

	// always drains the cycle after capture, no eviction can arrive while full
	always_ff @(posedge clock)
	begin
		if (reset)
			held <= 1'b0;
		else
			held <= victim_write;
	end

	always_ff @(posedge clock)
	begin
		if (victim_write)
		begin
			held_addr <= victim_addr;
			held_data <= victim_data;
		end
	end

	assign writeback_busy = held;

	// store has priority, fills are held off in dcache_mem meanwhile
	always_comb
	begin
		if (held)
		begin
			mem_command = dcache_pkg::bus_store;
			mem_addr = held_addr;
		end
		else if (fill_request)
		begin
			mem_command = dcache_pkg::bus_load;
			mem_addr = {lookup_tag, lookup_index};
		end
		else
		begin
			mem_command = dcache_pkg::bus_none;
			mem_addr = {lookup_tag, lookup_index};
		end
	end

	assign mem_store_data = held_data;

endmodule

//--- src/dcache_mem.sv
`timescale 1ns/100ps

module dcache_mem (
	input logic clock,
	input logic reset,
	input logic lookup_read,
	input logic lookup_write,
	input logic [dcache_pkg::index_bits-1:0] lookup_index,
	input logic [dcache_pkg::tag_bits-1:0] lookup_tag,
	input logic [dcache_pkg::block_bits-1:0] lookup_write_data,
	input logic writeback_busy,
	input logic [dcache_pkg::response_bits-1:0] mem_response,
	input logic [dcache_pkg::response_bits-1:0] mem_tag,
	input logic [dcache_pkg::block_bits-1:0] mem_load_data,
	output logic access_done,
	output logic [dcache_pkg::block_bits-1:0] read_data,
	output logic fill_request,
	output logic victim_write,
	output logic [dcache_pkg::addr_bits-1:0] victim_addr,
	output logic [dcache_pkg::block_bits-1:0] victim_data
);

	// block storage
	logic [dcache_pkg::block_bits-1:0] data_array [dcache_pkg::set_count][dcache_pkg::way_count];
	logic [dcache_pkg::tag_bits-1:0] tag_array [dcache_pkg::set_count][dcache_pkg::way_count];

	// per-line state
	logic [dcache_pkg::set_count-1:0][dcache_pkg::way_count-1:0] valid_array;
	logic [dcache_pkg::set_count-1:0][dcache_pkg::way_count-1:0] dirty_array;
	logic [dcache_pkg::set_count-1:0][dcache_pkg::way_count-1:0]
		[dcache_pkg::response_bits-1:0] response_array;

	// way to replace next, per set
	logic [dcache_pkg::set_count-1:0] lru_array;

	logic lookup_active;
	logic hit;
	logic hit_way;
	logic pending_match;
	logic miss;
	logic victim_way;
	logic victim_pending;
	logic victim_dirty;
	logic miss_allowed;
	logic evict;
	logic allocate_write;
	logic allocate_read;

	assign lookup_active = lookup_read || lookup_write;

	// compare both ways of the set
	always_comb
	begin
		hit = 1'b0;
		hit_way = 1'b0;
		pending_match = 1'b0;
		for (int w = 0; w < dcache_pkg::way_count; w++)
		begin
			if (tag_array[lookup_index][w] == lookup_tag)
			begin
				if (valid_array[lookup_index][w])
				begin
					hit = 1'b1;
					hit_way = 1'(w);
				end
				// a load for this block is already on its way
				if (response_array[lookup_index][w] != '0)
					pending_match = 1'b1;
			end
		end
	end

	assign miss = lookup_active && !hit && !pending_match;

	assign victim_way = lru_array[lookup_index];
	assign victim_pending = response_array[lookup_index][victim_way] != '0;
	assign victim_dirty = valid_array[lookup_index][victim_way]
		&& dirty_array[lookup_index][victim_way];

	// cache full or writeback register occupied
	assign miss_allowed = miss && !victim_pending && !writeback_busy;

	assign evict = miss_allowed && victim_dirty;
	assign allocate_write = miss_allowed && lookup_write;
	assign allocate_read = miss_allowed && lookup_read && !victim_dirty;

	assign access_done = (lookup_active && hit) || allocate_write;
	assign read_data = data_array[lookup_index][hit_way];
	assign fill_request = allocate_read;

	assign victim_write = evict;
	assign victim_addr = {tag_array[lookup_index][victim_way], lookup_index};
	assign victim_data = data_array[lookup_index][victim_way];

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			valid_array <= '0;
			dirty_array <= '0;
			response_array <= '0;
			lru_array <= '0;
		end
		else
		begin
			if (lookup_active && hit)
			begin
				lru_array[lookup_index] <= ~hit_way;
				if (lookup_write)
					dirty_array[lookup_index][hit_way] <= 1'b1;
			end

			// read keeps the old block as a clean copy and retries later
			if (evict && lookup_read)
				dirty_array[lookup_index][victim_way] <= 1'b0;

			if (allocate_write)
			begin
				valid_array[lookup_index][victim_way] <= 1'b1;
				dirty_array[lookup_index][victim_way] <= 1'b1;
				lru_array[lookup_index] <= ~victim_way;
			end

			if (allocate_read)
			begin
				valid_array[lookup_index][victim_way] <= 1'b0;
				dirty_array[lookup_index][victim_way] <= 1'b0;
				response_array[lookup_index][victim_way] <= mem_response;
				lru_array[lookup_index] <= ~victim_way;
			end

			// returning load data
			if (mem_tag != '0)
			begin
				for (int s = 0; s < dcache_pkg::set_count; s++)
				begin
					for (int w = 0; w < dcache_pkg::way_count; w++)
					begin
						if (response_array[s][w] == mem_tag)
						begin
							valid_array[s][w] <= 1'b1;
							dirty_array[s][w] <= 1'b0;
							response_array[s][w] <= '0;
						end
					end
				end
			end
		end
	end

	always_ff @(posedge clock)
	begin
		if (lookup_write && hit)
			data_array[lookup_index][hit_way] <= lookup_write_data;

		if (allocate_write)
		begin
			data_array[lookup_index][victim_way] <= lookup_write_data;
			tag_array[lookup_index][victim_way] <= lookup_tag;
		end

		if (allocate_read)
			tag_array[lookup_index][victim_way] <= lookup_tag;

		if (mem_tag != '0)
		begin
			for (int s = 0; s < dcache_pkg::set_count; s++)
			begin
				for (int w = 0; w < dcache_pkg::way_count; w++)
				begin
					if (response_array[s][w] == mem_tag)
						data_array[s][w] <= mem_load_data;
				end
			end
		end
	end

endmodule

//--- src/dcache_request_hold.sv
`timescale 1ns/100ps

module dcache_request_hold (
	input logic clock,
	input logic reset,
	input logic proc_read,
	input logic proc_write,
	input logic [dcache_pkg::addr_bits-1:0] proc_addr,
	input logic [dcache_pkg::block_bits-1:0] proc_write_data,
	input logic access_done,
	output logic proc_busy,
	output logic lookup_read,
	output logic lookup_write,
	output logic [dcache_pkg::index_bits-1:0] lookup_index,
	output logic [dcache_pkg::tag_bits-1:0] lookup_tag,
	output logic [dcache_pkg::block_bits-1:0] lookup_write_data
);

	logic held;
	logic held_write;
	logic [dcache_pkg::addr_bits-1:0] held_addr;
	logic [dcache_pkg::block_bits-1:0] held_data;
	logic accept;

	// new strobes only while idle
	assign accept = !held && (proc_read || proc_write);

	always_ff @(posedge clock)
	begin
		if (reset)
			held <= 1'b0;
		else if (held && access_done)
			held <= 1'b0;
		else if (accept)
			held <= 1'b1;
	end

	always_ff @(posedge clock)
	begin
		if (accept)
		begin
			held_write <= proc_write;
			held_addr <= proc_addr;
			held_data <= proc_write_data;
		end
	end

	assign proc_busy = held;

	// replayed every cycle until done
	assign lookup_read = held && !held_write;
	assign lookup_write = held && held_write;
	assign lookup_index = held_addr[dcache_pkg::index_bits-1:0];
	assign lookup_tag = held_addr[dcache_pkg::addr_bits-1:dcache_pkg::index_bits];
	assign lookup_write_data = held_data;

endmodule

//--- src/dcache_pkg.sv
package dcache_pkg;

	// cache geometry
	localparam int block_bits = 64;
	localparam int index_bits = 3;
	localparam int set_count = 1 << index_bits;

	// lru is one bit per set, so two ways only
	localparam int way_count = 2;

	// block address is {tag, index}
	localparam int addr_bits = 16;
	localparam int tag_bits = addr_bits - index_bits;

	// zero response or tag means none
	localparam int response_bits = 4;

	// memory bus command
	typedef enum logic [1:0]
	{
		bus_none = 2'd0,
		bus_load = 2'd1,
		bus_store = 2'd2
	} bus_command_t;

endpackage
